/* cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

  // datapath and memory word width
  localparam int WORD_W = 16;

  // one data or instruction word
  typedef logic [WORD_W-1:0] word_t;

  // index into the sixteen-entry register file
  typedef logic [3:0] reg_idx_t;

  // C to E are left unassigned and retire as no-ops
  typedef enum logic [3:0] {
    ADD = 4'h0,
    SUB = 4'h1,
    AND = 4'h2,
    OR  = 4'h3,
    XOR = 4'h4,
    SLL = 4'h5,
    SRA = 4'h6,
    ROR = 4'h7,
    LW  = 4'h8,
    SW  = 4'h9,
    LLB = 4'hA,
    LHB = 4'hB,
    HLT = 4'hF
  } opcode_e;

  // instruction field positions
  localparam int OPC_MSB  = 15;
  localparam int OPC_LSB  = 12;
  localparam int RD_MSB   = 11;
  localparam int RD_LSB   = 8;
  localparam int RS_MSB   = 7;
  localparam int RS_LSB   = 4;
  // rt field doubles as the 4-bit immediate
  localparam int RT_MSB   = 3;
  localparam int RT_LSB   = 0;
  localparam int IMM8_MSB = 7;
  localparam int IMM8_LSB = 0;

endpackage

`default_nettype wire

/* cpu_host_pkg.sv */
`default_nettype none

package cpu_host_pkg;

  // top two paddr bits select the region, the rest is a word offset
  localparam int REGION_MSB    = 15;
  localparam int REGION_LSB    = 14;
  localparam int HOST_OFFSET_W = 14;

  typedef logic [HOST_OFFSET_W-1:0] host_offset_t;

  typedef enum logic [1:0] {
    REGION_IMEM = 2'd0,
    REGION_DMEM = 2'd1,
    REGION_CTRL = 2'd2,
    REGION_NONE = 2'd3
  } host_region_e;

  // register offsets inside the CTRL region
  localparam host_offset_t CTRL_OFFSET   = 14'd0;
  localparam host_offset_t STATUS_OFFSET = 14'd1;

  // control and status bit positions
  localparam int CTRL_RUN_BIT       = 0;
  localparam int STATUS_HALTED_BIT  = 0;
  localparam int STATUS_RUNNING_BIT = 1;

endpackage

`default_nettype wire

/* cpu_exec_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one decoded instruction plus its register operands
interface cpu_exec_if import cpu_isa_pkg::*; ();

  // decoded fields, driven by fetch
  opcode_e  op;
  reg_idx_t rd;
  logic [3:0] imm4;
  logic [7:0] imm8;
  // high while the core is running
  logic     valid;

  // register read data, driven by the register file
  word_t    rs_data;
  word_t    rt_data;

  modport issue (output op, rd, imm4, imm8, valid);

  modport regs (input op, rd, valid, output rs_data, rt_data);

  modport alu (input op, rd, imm4, imm8, valid, rs_data, rt_data);

  modport lsu (input op, rd, imm4, imm8, valid, rs_data, rt_data);

endinterface

`default_nettype wire

/* cpu_host_if.sv */
`timescale 1ns/1ps
`default_nettype none

// host side access to the program and data memories
interface cpu_host_if import cpu_isa_pkg::*; import cpu_host_pkg::*; ();

  logic         req;
  // only IMEM and DMEM reach the memories
  host_region_e target;
  word_t        addr;
  word_t        wdata;
  logic         we;
  // each memory returns its own word, the APB block picks one
  word_t        imem_rdata;
  word_t        dmem_rdata;

  modport host (output req, target, addr, wdata, we, input imem_rdata, dmem_rdata);

  modport imem (input req, target, addr, wdata, we, output imem_rdata);

  modport dmem (input req, target, addr, wdata, we, output dmem_rdata);

endinterface

`default_nettype wire

/* cpu_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch import cpu_isa_pkg::*; import cpu_host_pkg::*; #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      start,
  input  logic      running,
  cpu_host_if.imem  host,
  cpu_exec_if.issue exe,
  output reg_idx_t  rs_sel,
  output reg_idx_t  rt_sel,
  output word_t     pc,
  output logic      halted
);

  localparam int IA = (IMEM_DEPTH > 1) ? $clog2(IMEM_DEPTH) : 1;

  word_t    imem [IMEM_DEPTH];
  word_t    instr;
  reg_idx_t rd_field;
  logic     byte_load;
  logic     hlt_now;
  logic     host_we;

  // word addressed, depth is a power of two so the pc wraps
  assign instr = imem[pc[IA-1:0]];

  // field split
  assign rd_field = instr[RD_MSB:RD_LSB];
  assign exe.op   = opcode_e'(instr[OPC_MSB:OPC_LSB]);
  assign exe.rd   = rd_field;
  assign exe.imm4 = instr[RT_MSB:RT_LSB];
  assign exe.imm8 = instr[IMM8_MSB:IMM8_LSB];
  assign exe.valid = running;

  // LLB and LHB merge into the old rd, so rd goes out on the rs port
  assign byte_load = (exe.op == LLB) || (exe.op == LHB);
  assign rs_sel = byte_load ? rd_field : instr[RS_MSB:RS_LSB];
  // memory and byte ops carry rd where rt would sit
  assign rt_sel = instr[OPC_MSB] ? rd_field : instr[RT_MSB:RT_LSB];

  assign hlt_now = running && (exe.op == HLT);

  // pc and halt flag
  // start wins over everything, HLT freezes the pc at its own address
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (start) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (hlt_now) begin
      halted <= 1'b1;
    end else if (running) begin
      pc <= pc + 16'd1;
    end
  end

  // host loads the program while the core is idle
  assign host_we = host.req && (host.target == REGION_IMEM) && host.we;

  always_ff @(posedge clk) begin
    if (host_we) begin
      imem[host.addr[IA-1:0]] <= host.wdata;
    end
  end

  assign host.imem_rdata = imem[host.addr[IA-1:0]];

  // halted pc stays put until the next start
  a_pc_frozen: assert property (@(posedge clk) disable iff (!arst_n)
    halted && !start |=> $stable(pc))
    else $error("pc moved while halted");

  // APB block must keep the host off imem during a run
  a_imem_idle: assert property (@(posedge clk) disable iff (!arst_n)
    running |-> !(host.req && host.target == REGION_IMEM))
    else $error("host imem access while running");

endmodule

`default_nettype wire

/* cpu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_alu import cpu_isa_pkg::*; (
  cpu_exec_if.alu exe,
  output word_t   alu_result
);

  word_t       a;
  word_t       b;
  logic [31:0] rot;

  // rs port holds the old rd for the byte loads
  assign a = exe.rs_data;
  assign b = exe.rt_data;

  // rotate through a doubled word, low half is the result
  assign rot = {a, a} >> exe.imm4;

  always_comb begin
    alu_result = '0;
    case (exe.op)
      // add and sub wrap, no flags
      ADD: alu_result = a + b;
      SUB: alu_result = a - b;
      AND: alu_result = a & b;
      OR:  alu_result = a | b;
      XOR: alu_result = a ^ b;
      // shift amount comes from the immediate field
      SLL: alu_result = a << exe.imm4;
      SRA: alu_result = word_t'($signed(a) >>> exe.imm4);
      ROR: alu_result = rot[15:0];
      // keep upper byte, new lower byte
      LLB: alu_result = {a[15:8], exe.imm8};
      // keep lower byte, new upper byte
      LHB: alu_result = {exe.imm8, a[7:0]};
      // memory ops, halt and unused codes produce nothing useful
      default: alu_result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* cpu_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_lsu import cpu_isa_pkg::*; import cpu_host_pkg::*; #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic     clk,
  input  logic     arst_n,
  cpu_exec_if.lsu  exe,
  cpu_host_if.dmem host,
  output word_t    load_data
);

  localparam int DA = (DMEM_DEPTH > 1) ? $clog2(DMEM_DEPTH) : 1;

  word_t         dmem [DMEM_DEPTH];
  word_t         offset;
  word_t         eff_addr;
  logic [DA-1:0] core_idx;
  logic [DA-1:0] host_idx;
  logic          core_we;
  logic          host_we;

  // sign-extended 4-bit offset
  assign offset = {{12{exe.imm4[3]}}, exe.imm4};

  // base register plus offset, wrapped into the array
  assign eff_addr = exe.rs_data + offset;
  assign core_idx = DA'(eff_addr % word_t'(DMEM_DEPTH));

  // index already range checked by the APB block
  assign host_idx = host.addr[DA-1:0];

  assign core_we = exe.valid && (exe.op == SW);
  assign host_we = host.req && (host.target == REGION_DMEM) && host.we;

  // store lands on the retiring edge
  // the host only gets the array while the core is idle
  always_ff @(posedge clk) begin
    if (core_we) begin
      dmem[core_idx] <= exe.rt_data;
    end else if (host_we) begin
      dmem[host_idx] <= host.wdata;
    end
  end

  // loads are combinational, the register file picks this up
  assign load_data = dmem[core_idx];

  assign host.dmem_rdata = dmem[host_idx];

  // core and host never write in the same cycle
  a_no_write_clash: assert property (@(posedge clk) disable iff (!arst_n)
    !(core_we && host_we))
    else $error("core and host dmem write in the same cycle");

endmodule

`default_nettype wire

/* cpu_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile import cpu_isa_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  cpu_exec_if.regs exe,
  input  reg_idx_t rs_sel,
  input  reg_idx_t rt_sel,
  input  word_t    alu_result,
  input  word_t    load_data
);

  word_t regs [16];
  logic  wr_en;
  word_t wr_data;

  // two asynchronous read ports
  assign exe.rs_data = regs[rs_sel];
  assign exe.rt_data = regs[rt_sel];

  // writeback select
  // LW takes the memory word, compute and byte ops take the ALU
  always_comb begin
    wr_en   = 1'b0;
    wr_data = alu_result;
    if (exe.valid) begin
      case (exe.op)
        ADD, SUB, AND, OR, XOR, SLL, SRA, ROR, LLB, LHB: begin
          wr_en = 1'b1;
        end
        LW: begin
          wr_en   = 1'b1;
          wr_data = load_data;
        end
        // SW, HLT and the unused codes leave the registers alone
        default: wr_en = 1'b0;
      endcase
    end
  end

  // r0 is an ordinary register here
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[exe.rd] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* cpu_apb_host.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_apb_host import cpu_isa_pkg::*; import cpu_host_pkg::*; #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 256
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     psel,
  input  logic     penable,
  input  logic     pwrite,
  input  word_t    paddr,
  input  word_t    pwdata,
  output word_t    prdata,
  output logic     pready,
  output logic     pslverr,
  input  logic     running,
  input  logic     halted,
  output logic     start,
  cpu_host_if.host host
);

  host_region_e region;
  host_offset_t idx;
  logic         access;
  logic         mem_region;
  logic         idx_bad;
  logic         err;
  word_t        ctrl_word;
  word_t        status_word;
  word_t        rdata;

  // access phase of a transfer, no wait states
  assign access = psel && penable;

  assign region = host_region_e'(paddr[REGION_MSB:REGION_LSB]);
  assign idx    = paddr[REGION_LSB-1:0];

  // region decode and range checks
  always_comb begin
    mem_region = 1'b0;
    idx_bad    = 1'b0;
    case (region)
      REGION_IMEM: begin
        mem_region = 1'b1;
        idx_bad    = 32'(idx) >= 32'(IMEM_DEPTH);
      end
      REGION_DMEM: begin
        mem_region = 1'b1;
        idx_bad    = 32'(idx) >= 32'(DMEM_DEPTH);
      end
      REGION_CTRL: idx_bad = (idx != CTRL_OFFSET) && (idx != STATUS_OFFSET);
      // unmapped region
      default: idx_bad = 1'b1;
    endcase
  end

  // memories are off limits during a run
  assign err = idx_bad || (mem_region && running);

  // CTRL reads back the run bit, STATUS reports both flags
  always_comb begin
    ctrl_word                     = '0;
    ctrl_word[CTRL_RUN_BIT]       = running;
    status_word                   = '0;
    status_word[STATUS_HALTED_BIT]  = halted;
    status_word[STATUS_RUNNING_BIT] = running;
  end

  always_comb begin
    rdata = '0;
    case (region)
      REGION_IMEM: rdata = host.imem_rdata;
      REGION_DMEM: rdata = host.dmem_rdata;
      REGION_CTRL: rdata = (idx == STATUS_OFFSET) ? status_word : ctrl_word;
      default:     rdata = '0;
    endcase
  end

  // response is valid in the access cycle only
  assign pready  = access;
  assign pslverr = access && err;
  assign prdata  = (access && !err && !pwrite) ? rdata : '0;

  // memory port, writes land on the edge closing the access cycle
  assign host.req    = access && mem_region && !err;
  assign host.target = region;
  assign host.addr   = {2'b00, idx};
  assign host.wdata  = pwdata;
  assign host.we     = pwrite;

  // one-cycle start on an accepted CTRL write with the run bit set
  assign start = access && pwrite && !err && (region == REGION_CTRL) &&
                 (idx == CTRL_OFFSET) && pwdata[CTRL_RUN_BIT];

  // penable only ever follows a selected setup cycle
  a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n)
    penable |-> psel)
    else $error("penable high without psel");

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_isa_pkg::*; #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 256
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  psel,
  input  logic  penable,
  input  logic  pwrite,
  input  word_t paddr,
  input  word_t pwdata,
  output word_t prdata,
  output logic  pready,
  output logic  pslverr,
  output logic  hlt,
  output word_t pc
);

  logic     running;
  logic     start;
  logic     halted;
  reg_idx_t rs_sel;
  reg_idx_t rt_sel;
  word_t    alu_result;
  word_t    load_data;

  cpu_exec_if exe_bus ();
  cpu_host_if host_bus ();

  // run flag, set by start and dropped on the edge that retires HLT
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end else if (exe_bus.valid && (exe_bus.op == HLT)) begin
      running <= 1'b0;
    end
  end

  assign hlt = halted;

  cpu_fetch #(
    .IMEM_DEPTH (IMEM_DEPTH)
  ) u_fetch (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (start),
    .running (running),
    .host    (host_bus.imem),
    .exe     (exe_bus.issue),
    .rs_sel  (rs_sel),
    .rt_sel  (rt_sel),
    .pc      (pc),
    .halted  (halted)
  );

  cpu_regfile u_regfile (
    .clk        (clk),
    .arst_n     (arst_n),
    .exe        (exe_bus.regs),
    .rs_sel     (rs_sel),
    .rt_sel     (rt_sel),
    .alu_result (alu_result),
    .load_data  (load_data)
  );

  // both units see the same operands every cycle
  cpu_alu u_alu (
    .exe        (exe_bus.alu),
    .alu_result (alu_result)
  );

  cpu_lsu #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_lsu (
    .clk       (clk),
    .arst_n    (arst_n),
    .exe       (exe_bus.lsu),
    .host      (host_bus.dmem),
    .load_data (load_data)
  );

  cpu_apb_host #(
    .IMEM_DEPTH (IMEM_DEPTH),
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_apb_host (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .running (running),
    .halted  (halted),
    .start   (start),
    .host    (host_bus.host)
  );

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import cpu_isa_pkg::*; import cpu_host_pkg::*; #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 256
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  psel,
  input  logic  penable,
  input  logic  pwrite,
  input  word_t paddr,
  input  word_t pwdata,
  input  word_t prdata,
  input  logic  pready,
  input  logic  pslverr,
  input  logic  hlt,
  input  word_t pc,
  input  logic  test_done,
  output int    checks,
  output int    errors
);

  // reference state, rebuilt from the host writes seen on APB
  word_t m_imem [IMEM_DEPTH];
  word_t m_dmem [DMEM_DEPTH];
  word_t m_regs [16];

  logic started;
  // negedges since the last accepted start
  int   cyc;
  int   hlt_idx;
  int   tests;
  int   checks_mark;
  int   errors_mark;

  initial begin
    started     = 1'b0;
    cyc         = 0;
    hlt_idx     = 0;
    tests       = 0;
    checks      = 0;
    errors      = 0;
    checks_mark = 0;
    errors_mark = 0;
    // registers come out of reset cleared
    for (int i = 0; i < 16; i++) begin
      m_regs[i] = '0;
    end
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      m_imem[i] = '0;
    end
    for (int i = 0; i < DMEM_DEPTH; i++) begin
      m_dmem[i] = '0;
    end
  end

  task automatic compare(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // sign bits fill in from the top
  function automatic word_t shift_right_arith(input word_t a, input logic [3:0] sh);
    word_t r;
    r = a >> sh;
    if (a[15]) begin
      r = r | ~(16'hFFFF >> sh);
    end
    return r;
  endfunction

  function automatic word_t rotate_right(input word_t a, input logic [3:0] sh);
    if (sh == 4'd0) begin
      return a;
    end
    return (a >> sh) | (a << (5'd16 - {1'b0, sh}));
  endfunction

  // instruction level run from pc 0 up to the first HLT
  task automatic execute_program();
    word_t      w;
    word_t      a;
    word_t      b;
    word_t      sum;
    logic [3:0] op;
    logic [3:0] rd;
    logic [3:0] sh;
    logic [3:0] ra;
    logic [3:0] rb;
    int         p;
    int         steps;
    int         ea;
    p       = 0;
    steps   = 0;
    hlt_idx = -1;
    while (hlt_idx < 0 && steps < 4 * IMEM_DEPTH) begin
      w  = m_imem[p];
      op = w[OPC_MSB:OPC_LSB];
      rd = w[RD_MSB:RD_LSB];
      sh = w[RT_MSB:RT_LSB];
      // byte loads read the old rd, memory ops take their data register from rd
      ra = (op == LLB || op == LHB) ? rd : w[RS_MSB:RS_LSB];
      rb = (op >= 4'h8) ? rd : w[RT_MSB:RT_LSB];
      a  = m_regs[ra];
      b  = m_regs[rb];
      // base plus sign-extended offset, wrapped into the data memory
      sum = a + {{12{sh[3]}}, sh};
      ea  = int'(sum) % DMEM_DEPTH;
      case (op)
        ADD: m_regs[rd] = a + b;
        SUB: m_regs[rd] = a - b;
        AND: m_regs[rd] = a & b;
        OR:  m_regs[rd] = a | b;
        XOR: m_regs[rd] = a ^ b;
        SLL: m_regs[rd] = a << sh;
        SRA: m_regs[rd] = shift_right_arith(a, sh);
        ROR: m_regs[rd] = rotate_right(a, sh);
        LW:  m_regs[rd] = m_dmem[ea];
        SW:  m_dmem[ea] = b;
        LLB: m_regs[rd] = {a[15:8], w[7:0]};
        LHB: m_regs[rd] = {w[7:0], a[7:0]};
        HLT: hlt_idx = p;
        // C to E retire with no effect
        default: ;
      endcase
      if (hlt_idx < 0) begin
        p = (p + 1) % IMEM_DEPTH;
      end
      steps++;
    end
    if (hlt_idx < 0) begin
      errors++;
      $display("model error: the loaded program never reaches HLT");
      hlt_idx = 1 << 20;
    end
  endtask

  task automatic watch_cycle();
    logic       run_now;
    logic       halt_now;
    logic       access;
    logic       exp_err;
    logic [1:0] region;
    int         idx;
    word_t      exp_pc;
    word_t      exp_rd;
    if (started) begin
      cyc++;
    end
    // instruction i is current during the (i+1)th cycle after start
    run_now  = started && (cyc >= 1) && (cyc <= hlt_idx + 1);
    halt_now = started && (cyc >= hlt_idx + 2);
    exp_pc   = run_now ? word_t'(cyc - 1) : (halt_now ? word_t'(hlt_idx) : '0);
    compare("pc", pc, exp_pc);
    compare("hlt", word_t'(hlt), word_t'(halt_now));
    access = psel && penable;
    compare("pready", word_t'(pready), word_t'(access));
    if (!access) begin
      compare("pslverr outside access", word_t'(pslverr), '0);
    end else begin
      region = paddr[REGION_MSB:REGION_LSB];
      idx    = int'(paddr[REGION_LSB-1:0]);
      case (region)
        REGION_IMEM: exp_err = (idx >= IMEM_DEPTH) || run_now;
        REGION_DMEM: exp_err = (idx >= DMEM_DEPTH) || run_now;
        REGION_CTRL: exp_err = (idx != int'(CTRL_OFFSET)) && (idx != int'(STATUS_OFFSET));
        default:     exp_err = 1'b1;
      endcase
      compare($sformatf("pslverr at %h", paddr), word_t'(pslverr), word_t'(exp_err));
      if (!pwrite) begin
        exp_rd = '0;
        if (!exp_err && region == REGION_IMEM) begin
          exp_rd = m_imem[idx];
        end else if (!exp_err && region == REGION_DMEM) begin
          exp_rd = m_dmem[idx];
        end else if (!exp_err) begin
          exp_rd[STATUS_HALTED_BIT]  = halt_now;
          exp_rd[STATUS_RUNNING_BIT] = run_now;
        end
        // CTRL itself has no defined read value
        if (exp_err || region != REGION_CTRL || idx == int'(STATUS_OFFSET)) begin
          compare($sformatf("read of %h", paddr), prdata, exp_rd);
        end
      end else if (!exp_err) begin
        if (region == REGION_IMEM) begin
          m_imem[idx] = pwdata;
        end else if (region == REGION_DMEM) begin
          m_dmem[idx] = pwdata;
        end else if (idx == int'(CTRL_OFFSET) && pwdata[CTRL_RUN_BIT]) begin
          // a run starts on the next edge
          execute_program();
          started = 1'b1;
          cyc     = 0;
        end
      end
    end
  endtask

  task automatic report_test();
    tests++;
    $display("test %0d done: %0d checks, %0d mismatches", tests,
             checks - checks_mark, errors - errors_mark);
    checks_mark = checks;
    errors_mark = errors;
  endtask

  // mid-cycle sampling, all DUT inputs change on the rising edge
  always @(negedge clk) begin
    if (arst_n) begin
      watch_cycle();
      if (test_done) begin
        report_test();
      end
    end
  end

endmodule

`default_nettype wire

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_isa_pkg::*; import cpu_host_pkg::*; #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 256
);

  localparam int          N_TESTS   = 8;
  localparam int          MIN_BODY  = 20;
  localparam int          MAX_BODY  = 40;
  // base setup, sixteen stores and HLT follow the random body
  localparam int          MAX_PROG  = MAX_BODY + 19;
  localparam int          DUMP_BASE = 200;
  localparam logic [31:0] SEED      = 32'h95d0_c9c6;
  // per test: run length plus APB traffic plus polling slack
  localparam int TEST_CYCLES = MAX_PROG + 4 * (MAX_PROG + 2 * DMEM_DEPTH + 10) + 200;
  // one extra slot for the idle memory test
  localparam int LIMIT       = (N_TESTS + 1) * TEST_CYCLES;

  logic  clk;
  logic  arst_n;
  logic  psel;
  logic  penable;
  logic  pwrite;
  word_t paddr;
  word_t pwdata;
  word_t prdata;
  logic  pready;
  logic  pslverr;
  logic  hlt;
  word_t pc;
  logic  test_done;
  int    checks;
  int    errors;
  int    cycles;

  cpu_top #(
    .IMEM_DEPTH (IMEM_DEPTH),
    .DMEM_DEPTH (DMEM_DEPTH)
  ) DUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .hlt     (hlt),
    .pc      (pc)
  );

  tb_checker #(
    .IMEM_DEPTH (IMEM_DEPTH),
    .DMEM_DEPTH (DMEM_DEPTH)
  ) chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .hlt       (hlt),
    .pc        (pc),
    .test_done (test_done),
    .checks    (checks),
    .errors    (errors)
  );

  // 100 ns period
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  function automatic word_t host_addr(input host_region_e region, input int index);
    return {region, 14'(index)};
  endfunction

  // setup cycle, access cycle, then one idle cycle
  task automatic apb_transfer(input logic wr, input word_t addr, input word_t wdata,
                              output word_t rdata);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input word_t addr, input word_t data);
    word_t unused;
    apb_transfer(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input word_t addr, output word_t data);
    apb_transfer(1'b0, addr, '0, data);
  endtask

  // one-cycle marker so the checker closes the test
  task automatic end_test();
    @(posedge clk);
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  // both memories hold what the host wrote while idle
  task automatic idle_memory_test();
    int    imem_at [8];
    int    dmem_at [8];
    word_t rd_word;
    for (int i = 0; i < 8; i++) begin
      imem_at[i] = int'($urandom % IMEM_DEPTH);
      dmem_at[i] = int'($urandom % DMEM_DEPTH);
      apb_write(host_addr(REGION_IMEM, imem_at[i]), word_t'($urandom));
      apb_write(host_addr(REGION_DMEM, dmem_at[i]), word_t'($urandom));
    end
    for (int i = 0; i < 8; i++) begin
      apb_read(host_addr(REGION_IMEM, imem_at[i]), rd_word);
      apb_read(host_addr(REGION_DMEM, dmem_at[i]), rd_word);
    end
    end_test();
  endtask

  task automatic run_program_test();
    word_t      prog [$];
    word_t      status;
    word_t      rd_word;
    int         n_body;
    logic [3:0] op;
    n_body = MIN_BODY + int'($urandom % (MAX_BODY - MIN_BODY + 1));
    // random body, any opcode except HLT
    for (int i = 0; i < n_body; i++) begin
      op = 4'($urandom % 15);
      prog.push_back({op, 12'($urandom)});
    end
    // r15 points 8 above the dump area so offsets -8..7 cover it
    prog.push_back({LLB, 4'd15, 8'(DUMP_BASE + 8)});
    prog.push_back({LHB, 4'd15, 8'h00});
    // r15 goes last and stores its own base
    for (int k = 0; k < 16; k++) begin
      prog.push_back({SW, 4'(k), 4'd15, 4'(k - 8)});
    end
    prog.push_back({HLT, 12'h000});

    foreach (prog[i]) begin
      apb_write(host_addr(REGION_IMEM, i), prog[i]);
    end
    for (int a = 0; a < DMEM_DEPTH; a++) begin
      apb_write(host_addr(REGION_DMEM, a), word_t'($urandom));
    end
    apb_write(host_addr(REGION_CTRL, CTRL_OFFSET), 16'(1 << CTRL_RUN_BIT));

    // memory traffic during the run must be refused
    // the data write aims below the dump area, which the run rewrites
    apb_write(host_addr(REGION_DMEM, int'($urandom % DUMP_BASE)), word_t'($urandom));
    apb_write(host_addr(REGION_IMEM, int'($urandom % prog.size())), word_t'($urandom));
    apb_read(host_addr(REGION_DMEM, int'($urandom % DMEM_DEPTH)), rd_word);

    status = '0;
    while (!status[STATUS_HALTED_BIT]) begin
      apb_read(host_addr(REGION_CTRL, STATUS_OFFSET), status);
    end

    // unmapped region, bad CTRL offset, indexes past the end
    apb_write(host_addr(REGION_NONE, int'($urandom % 16384)), word_t'($urandom));
    apb_read(host_addr(REGION_NONE, int'($urandom % 16384)), rd_word);
    apb_write(host_addr(REGION_CTRL, 2 + int'($urandom % 100)), 16'(1 << CTRL_RUN_BIT));
    apb_write(host_addr(REGION_DMEM, DMEM_DEPTH + int'($urandom % 100)), word_t'($urandom));
    apb_write(host_addr(REGION_IMEM, IMEM_DEPTH + int'($urandom % 100)), word_t'($urandom));
    apb_read(host_addr(REGION_DMEM, DMEM_DEPTH + int'($urandom % 100)), rd_word);
    apb_read(host_addr(REGION_CTRL, STATUS_OFFSET), status);

    // full data image, then the program itself
    for (int a = 0; a < DMEM_DEPTH; a++) begin
      apb_read(host_addr(REGION_DMEM, a), rd_word);
    end
    foreach (prog[i]) begin
      apb_read(host_addr(REGION_IMEM, i), rd_word);
    end
    end_test();
  endtask

  initial begin
    void'($urandom(SEED));
    clk       = 1'b0;
    arst_n    = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    test_done = 1'b0;
    cycles    = 0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    idle_memory_test();
    for (int t = 0; t < N_TESTS; t++) begin
      run_program_test();
    end

    repeat (2) @(posedge clk);
    $display("%0d tests, %0d checks, %0d mismatches", N_TESTS + 1, checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
cpu_isa_pkg.sv
cpu_host_pkg.sv
cpu_exec_if.sv
cpu_host_if.sv
cpu_fetch.sv
cpu_alu.sv
cpu_lsu.sv
cpu_regfile.sv
cpu_apb_host.sv
cpu_top.sv
tb_checker.sv
tb_cpu.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, pass only on the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing -Wno-fatal --top-module tb_cpu -f verilog.f -o tb_cpu_sim &&
  ./obj_dir/tb_cpu_sim | tee /dev/stderr | grep -qx "No errors" ||
  exit 1
